//--- tb.f
+incdir+common
common/tcb_pkg.sv
common/trace_pkg.sv
common/trace_stream_if.sv
trace_capture/trace_capture.sv
rtl/trace_fifo.sv
rtl/trace_apb_reader.sv
rtl/trace_unit.sv
tests/trace_unit_tb.sv

//--- Makefile
# Verilator build and run of the trace unit testbench

TOP = trace_unit_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

# pass only if the run prints the pass message
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- tests/trace_unit_tb.sv
////////////////////
// self-checking testbench for the commit trace unit
// drives fetch, load/store and write-back, drains records over APB
////////////////////

`include "trace_settings.svh"

module trace_unit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned APB_TIMEOUT = 16;

  logic        tcb_ifu;
  logic        arst_n;
  logic        ifu_vld, ifu_rdy;
  logic [31:0] ifu_adr, ifu_rdt;
  logic        lsu_vld, lsu_rdy, lsu_wen;
  logic [31:0] lsu_adr, lsu_wdt, lsu_rdt;
  logic        gpr_wen;
  logic [4:0]  gpr_wid;
  logic [31:0] gpr_wdt;
  logic        psel, penable, pwrite;
  logic [4:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr;

  // bus activity requested for the next cycle
  logic        f_en, g_en, l_en, l_wen;
  logic [31:0] f_pc, f_insn, g_dt, l_adr, l_wdt, l_rdt;
  logic [4:0]  g_id;
  // response data due one cycle after a transfer
  logic [31:0] ifu_rdt_nxt, lsu_rdt_nxt;

  // log of the open window
  logic        win_open;
  logic [31:0] win_pc, win_insn;
  logic [36:0] gpr_log [$];
  logic [96:0] lsu_log [$];
  // expected records in push order
  trace_pkg::trace_rec_t exp_q [$];

  logic [31:0] lfsr;
  string       test_name;
  int          test_errs, errs_total, tests_run, tests_failed;

  trace_unit trace_unit_i (.*);

  initial begin
    tcb_ifu = 1'b0;
    forever #2 tcb_ifu = ~tcb_ifu;
  end

  ////////////////////
  // helpers
  ////////////////////

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'hd000_0001 : 32'h0);
      v    = {v[30:0], b};
    end
    return v;
  endfunction

  // expected record of the logged window
  function automatic trace_pkg::trace_rec_t trace_expect(input logic [31:0] pc,
                                                         input logic [31:0] insn);
    trace_pkg::trace_rec_t r;
    logic [96:0]           ev;
    r      = '0;
    r.pc   = pc;
    // compressed: upper half dropped
    r.insn = (insn[1:0] == 2'b11) ? insn : {16'h0000, insn[15:0]};
    // last write with a nonzero index
    foreach (gpr_log[i]) begin
      if (gpr_log[i][36:32] != 5'd0) begin
        r.gpr_vld = 1'b1;
        r.gpr_wid = gpr_log[i][36:32];
        r.gpr_wdt = gpr_log[i][31:0];
      end
    end
    // last load or store, loads report response data
    if (lsu_log.size() != 0) begin
      ev        = lsu_log[$];
      r.lsu_vld = 1'b1;
      r.lsu_wen = ev[96];
      r.lsu_adr = ev[95:64];
      r.lsu_dat = ev[96] ? ev[63:32] : ev[31:0];
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errs++;
      errs_total++;
    end
  endtask

  task automatic set_fetch(input logic cmp);
    logic [31:0] r;
    r           = rand_bits(30);
    f_en        = 1'b1;
    f_pc        = {r[29:0], 2'b00};
    f_insn      = rand_bits(32);
    f_insn[1:0] = cmp ? 2'b01 : 2'b11;
  endtask

  task automatic set_gpr(input logic [4:0] id);
    g_en = 1'b1;
    g_id = id;
    g_dt = rand_bits(32);
  endtask

  task automatic set_lsu(input logic wen);
    logic [31:0] r;
    r     = rand_bits(30);
    l_en  = 1'b1;
    l_wen = wen;
    l_adr = {r[29:0], 2'b00};
    l_wdt = wen ? rand_bits(32) : 32'h0;
    l_rdt = wen ? 32'h0 : rand_bits(32);
  endtask

  // one bus cycle, driven on the falling edge, logged per window
  task automatic step();
    @(negedge tcb_ifu);
    ifu_vld = f_en;
    ifu_adr = f_pc;
    ifu_rdt = ifu_rdt_nxt;
    gpr_wen = g_en;
    gpr_wid = g_id;
    gpr_wdt = g_dt;
    lsu_vld = l_en;
    lsu_wen = l_wen;
    lsu_adr = l_adr;
    lsu_wdt = l_wdt;
    lsu_rdt = lsu_rdt_nxt;
    ifu_rdt_nxt = f_en ? f_insn : 32'h0;
    lsu_rdt_nxt = (l_en && !l_wen) ? l_rdt : 32'h0;
    // the fetch cycle still belongs to the old window
    if (win_open && g_en) gpr_log.push_back({g_id, g_dt});
    if (win_open && l_en) lsu_log.push_back({l_wen, l_adr, l_wdt, l_rdt});
    if (f_en) begin
      if (win_open) exp_q.push_back(trace_expect(win_pc, win_insn));
      win_open = 1'b1;
      win_pc   = f_pc;
      win_insn = f_insn;
      gpr_log.delete();
      lsu_log.delete();
    end
    f_en = 1'b0;
    g_en = 1'b0;
    l_en = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  task automatic apply_reset();
    arst_n      = 1'b0;
    win_open    = 1'b0;
    ifu_rdt_nxt = '0;
    lsu_rdt_nxt = '0;
    gpr_log.delete();
    lsu_log.delete();
    exp_q.delete();
    repeat (16) @(negedge tcb_ifu);
    arst_n = 1'b1;
  endtask

  ////////////////////
  // APB master
  ////////////////////

  task automatic apb_xfer(input logic wr, input logic [4:0] adr, input logic [31:0] wdt,
                          output logic [31:0] rdt, output logic err);
    int n;
    @(negedge tcb_ifu);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = adr;
    pwdata  = wdt;
    @(negedge tcb_ifu);
    penable = 1'b1;
    n = 0;
    // pready sampled on falling edges
    while (!pready && n < APB_TIMEOUT) begin
      @(negedge tcb_ifu);
      n++;
    end
    if (!pready) begin
      $display("%s: APB access to 0x%02h never completed, no pready", test_name, adr);
      test_errs++;
      errs_total++;
      rdt = '0;
      err = 1'b1;
    end else begin
      rdt = prdata;
      err = pslverr;
    end
    // hold through the completing edge
    @(negedge tcb_ifu);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // compare the seven record words, the last read pops
  task automatic check_head(input trace_pkg::trace_rec_t e);
    logic [31:0] w [8];
    logic [31:0] d;
    logic        err;
    w[0] = '0;
    w[1] = e.pc;
    w[2] = e.insn;
    w[3] = {23'd0, e.gpr_vld, 3'd0, e.gpr_wid};
    w[4] = e.gpr_wdt;
    w[5] = {30'd0, e.lsu_vld, e.lsu_wen};
    w[6] = e.lsu_adr;
    w[7] = e.lsu_dat;
    for (int a = 1; a < 8; a++) begin
      apb_xfer(1'b0, 5'(a * 4), '0, d, err);
      check_value($sformatf("reg 0x%02h", a * 4), w[a], d);
      check_value($sformatf("reg 0x%02h pslverr", a * 4), 32'd0, 32'(err));
    end
  endtask

  // status before each record, records in push order
  task automatic drain(input logic [15:0] drop);
    logic [31:0] d;
    logic        err;
    while (exp_q.size() != 0) begin
      apb_xfer(1'b0, 5'h00, '0, d, err);
      check_value("status", {drop, 16'(exp_q.size())}, d);
      check_head(exp_q.pop_front());
    end
    apb_xfer(1'b0, 5'h00, '0, d, err);
    check_value("status empty", {drop, 16'd0}, d);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
    apply_reset();
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, test_errs);
    end
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    logic [31:0] d;
    logic        err;
    {ifu_vld, ifu_adr, ifu_rdt, lsu_vld, lsu_wen, lsu_adr, lsu_wdt, lsu_rdt} = '0;
    {gpr_wen, gpr_wid, gpr_wdt, psel, penable, pwrite, paddr, pwdata} = '0;
    {f_en, g_en, l_en, l_wen, f_pc, f_insn, g_dt, g_id, l_adr, l_wdt, l_rdt} = '0;
    ifu_rdy = 1'b1;
    lsu_rdy = 1'b1;
    arst_n  = 1'b0;
    lfsr    = 32'hee12_989e;
    {test_errs, errs_total, tests_run, tests_failed} = '0;

    start_test("reset");
    apb_xfer(1'b0, 5'h00, '0, d, err);
    check_value("status", 32'd0, d);
    check_value("status pslverr", 32'd0, 32'(err));
    apb_xfer(1'b0, 5'h04, '0, d, err);
    check_value("empty pc", 32'd0, d);
    check_value("empty pc pslverr", 32'd1, 32'(err));
    end_test();

    // six fetches close five windows
    start_test("fetch_only");
    for (int i = 0; i < 6; i++) begin
      set_fetch(i % 3 == 1);
      step();
      step();
    end
    idle(4);
    apb_xfer(1'b0, 5'h00, '0, d, err);
    check_value("level", 32'd5, d);
    drain(16'd0);
    end_test();

    start_test("gpr_write");
    set_fetch(1'b0);
    step();
    set_gpr(5'd5);
    step();
    set_gpr(5'd9);
    step();
    set_gpr(5'd0);
    step();
    // write in the closing cycle is still the last one
    set_fetch(1'b1);
    set_gpr(5'd3);
    step();
    step();
    set_gpr(5'd0);
    step();
    set_fetch(1'b0);
    step();
    idle(4);
    drain(16'd0);
    end_test();

    start_test("load_store");
    set_fetch(1'b0);
    step();
    set_lsu(1'b1);
    step();
    step();
    set_fetch(1'b0);
    step();
    set_lsu(1'b0);
    step();
    step();
    set_fetch(1'b1);
    step();
    set_lsu(1'b1);
    step();
    // load in the closing cycle, data after the window
    set_lsu(1'b0);
    set_fetch(1'b0);
    step();
    // load whose data lands in the closing cycle
    set_lsu(1'b0);
    step();
    set_fetch(1'b0);
    step();
    idle(4);
    drain(16'd0);
    end_test();

    // ten records into eight slots
    start_test("overflow");
    for (int i = 0; i < 11; i++) begin
      set_fetch(i[0]);
      step();
    end
    idle(4);
    apb_xfer(1'b0, 5'h00, '0, d, err);
    check_value("full status", {16'(10 - `TRACE_FIFO_DEPTH), 16'(`TRACE_FIFO_DEPTH)}, d);
    apb_xfer(1'b1, 5'h00, '0, d, err);
    check_value("status write pslverr", 32'd0, 32'(err));
    while (exp_q.size() > `TRACE_FIFO_DEPTH) void'(exp_q.pop_back());
    drain(16'd0);
    end_test();

    start_test("bad_write");
    set_fetch(1'b0);
    step();
    step();
    set_fetch(1'b1);
    step();
    idle(4);
    apb_xfer(1'b1, 5'h04, 32'h1234_5678, d, err);
    check_value("pc write pslverr", 32'd1, 32'(err));
    drain(16'd0);
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errs_total);
    if (errs_total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- rtl/trace_unit.sv
////////////////////
// commit trace unit top level with plain bus ports
// capture feeds the buffer, APB drains it
////////////////////

`include "trace_settings.svh"

module trace_unit (
  input  logic                    tcb_ifu,
  input  logic                    arst_n,
  // instruction fetch bus
  input  logic                    ifu_vld,
  input  logic                    ifu_rdy,
  input  logic [`TRACE_XLEN-1:0]  ifu_adr,
  input  logic [`TRACE_XLEN-1:0]  ifu_rdt,
  // load/store bus
  input  logic                    lsu_vld,
  input  logic                    lsu_rdy,
  input  logic                    lsu_wen,
  input  logic [`TRACE_XLEN-1:0]  lsu_adr,
  input  logic [`TRACE_XLEN-1:0]  lsu_wdt,
  input  logic [`TRACE_XLEN-1:0]  lsu_rdt,
  // register write-back
  input  logic                    gpr_wen,
  input  logic [`TRACE_GLOG-1:0]  gpr_wid,
  input  logic [`TRACE_XLEN-1:0]  gpr_wdt,
  // APB
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [4:0]              paddr,
  input  logic [`TRACE_XLEN-1:0]  pwdata,
  output logic [`TRACE_XLEN-1:0]  prdata,
  output logic                    pready,
  output logic                    pslverr
);

  tcb_pkg::tcb_req_t ifu_req;
  tcb_pkg::tcb_req_t lsu_req;
  logic                    push_vld;
  logic                    push_rdy;
  trace_pkg::trace_rec_t   push_rec;
  logic                    drop_clr;
  logic [`TRACE_DROP_W-1:0] drop_cnt;

  trace_stream_if pop_if ();

  // fetch bus never writes
  assign ifu_req = '{adr: ifu_adr, wen: 1'b0, wdt: '0};
  assign lsu_req = '{adr: lsu_adr, wen: lsu_wen, wdt: lsu_wdt};

  trace_capture trace_capture_i (
    .tcb_ifu, .arst_n,
    .ifu_vld, .ifu_rdy, .ifu_req, .ifu_rdt,
    .lsu_vld, .lsu_rdy, .lsu_req, .lsu_rdt,
    .gpr_wen, .gpr_wid, .gpr_wdt,
    .push_vld, .push_rdy, .push_rec,
    .drop_clr, .drop_cnt
  );

  trace_fifo trace_fifo_i (
    .tcb_ifu, .arst_n,
    .push_vld, .push_rdy, .push_rec,
    .pop (pop_if.src)
  );

  trace_apb_reader trace_apb_reader_i (
    .tcb_ifu, .arst_n,
    .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .pop (pop_if.snk),
    .drop_cnt, .drop_clr
  );

endmodule

//--- rtl/trace_apb_reader.sv
////////////////////
// APB slave for draining trace records word by word
// status sits at 0x00 and the record words above it
// a read of 0x1C pops the head record
////////////////////

`include "trace_settings.svh"

module trace_apb_reader (
  input  logic                     tcb_ifu,
  input  logic                     arst_n,
  // APB
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [4:0]               paddr,
  input  logic [`TRACE_XLEN-1:0]   pwdata,
  output logic [`TRACE_XLEN-1:0]   prdata,
  output logic                     pready,
  output logic                     pslverr,
  // buffer head
  trace_stream_if.snk              pop,
  // drop counter from capture
  input  logic [`TRACE_DROP_W-1:0] drop_cnt,
  output logic                     drop_clr
);

  trace_pkg::trace_reg_e  reg_adr;
  // first access-phase cycle
  logic                   acc_cyc;
  logic [`TRACE_XLEN-1:0] rd_dat;
  logic                   rd_err;
  logic                   err;

  assign reg_adr = trace_pkg::trace_reg_e'(paddr[4:2]);
  assign acc_cyc = psel & penable & ~pready;

  ////////////////////
  // register decode
  ////////////////////

  always_comb begin
    rd_dat = '0;
    rd_err = 1'b0;
    if (reg_adr == trace_pkg::REG_STATUS) begin
      rd_dat[`TRACE_XLEN-1 -: `TRACE_DROP_W] = drop_cnt;
      rd_dat[$bits(trace_pkg::trace_lvl_t)-1:0] = pop.lvl;
    end else if (!pop.vld) begin
      // record words of an empty buffer
      rd_err = 1'b1;
    end else begin
      case (reg_adr)
        trace_pkg::REG_PC:      rd_dat = pop.rec.pc;
        trace_pkg::REG_INSN:    rd_dat = pop.rec.insn;
        trace_pkg::REG_GPR_CTL: begin
          rd_dat[8] = pop.rec.gpr_vld;
          rd_dat[`TRACE_GLOG-1:0] = pop.rec.gpr_wid;
        end
        trace_pkg::REG_GPR_DAT: rd_dat = pop.rec.gpr_wdt;
        trace_pkg::REG_LSU_CTL: rd_dat[1:0] = {pop.rec.lsu_vld, pop.rec.lsu_wen};
        trace_pkg::REG_LSU_ADR: rd_dat = pop.rec.lsu_adr;
        default:                rd_dat = pop.rec.lsu_dat;
      endcase
    end
  end

  // only status is writable
  // misaligned access always fails
  assign err = (paddr[1:0] != 2'b00) |
               (pwrite ? (reg_adr != trace_pkg::REG_STATUS) : rd_err);

  // one wait state before completion
  // pop and clear land in the completing cycle
  always_ff @(posedge tcb_ifu or negedge arst_n) begin
    if (!arst_n) begin
      pready   <= 1'b0;
      pslverr  <= 1'b0;
      pop.rdy  <= 1'b0;
      drop_clr <= 1'b0;
    end else begin
      pready   <= acc_cyc;
      pslverr  <= acc_cyc & err;
      pop.rdy  <= acc_cyc & ~pwrite & ~err & (reg_adr == trace_pkg::REG_LSU_DAT);
      drop_clr <= acc_cyc & pwrite & ~err;
    end
  end

  always_ff @(posedge tcb_ifu) begin
    if (acc_cyc) prdata <= (pwrite || err) ? '0 : rd_dat;
  end

  // penable only inside a selected transfer, raised after a setup phase
  a_apb_setup: assert property (
    @(posedge tcb_ifu) disable iff (!arst_n)
    penable |-> psel && (!$rose(penable) || $past(psel))
  );

  a_apb_wdata: assert property (
    @(posedge tcb_ifu) disable iff (!arst_n)
    acc_cyc && pwrite |-> !$isunknown(pwdata)
  );

endmodule

//--- rtl/trace_fifo.sv
////////////////////
// circular record buffer between capture and APB reader
// head record and level are shown one cycle after a push
////////////////////

`include "trace_settings.svh"

module trace_fifo (
  input  logic                  tcb_ifu,
  input  logic                  arst_n,
  input  logic                  push_vld,
  output logic                  push_rdy,
  input  trace_pkg::trace_rec_t push_rec,
  trace_stream_if.src           pop
);

  localparam int unsigned DEPTH = `TRACE_FIFO_DEPTH;
  localparam int unsigned AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // record storage
  trace_pkg::trace_rec_t mem [DEPTH];
  logic [AW-1:0]         wptr;
  logic [AW-1:0]         rptr;
  trace_pkg::trace_lvl_t lvl;
  logic                  push_trn;
  logic                  pop_trn;

  // pointer increment with wrap at the depth
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH-1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_rdy = (lvl != trace_pkg::trace_lvl_t'(DEPTH));
  assign push_trn = push_vld & push_rdy;
  assign pop_trn  = pop.vld & pop.rdy;

  // head of buffer
  assign pop.vld = (lvl != '0);
  assign pop.rec = mem[rptr];
  assign pop.lvl = lvl;

  always_ff @(posedge tcb_ifu) begin
    if (push_trn) mem[wptr] <= push_rec;
  end

  always_ff @(posedge tcb_ifu or negedge arst_n) begin
    if (!arst_n) begin
      wptr <= '0;
      rptr <= '0;
      lvl  <= '0;
    end else begin
      if (push_trn) wptr <= ptr_inc(wptr);
      if (pop_trn)  rptr <= ptr_inc(rptr);
      // simultaneous push and pop keeps the level
      if (push_trn && !pop_trn)      lvl <= lvl + 1'b1;
      else if (!push_trn && pop_trn) lvl <= lvl - 1'b1;
    end
  end

  a_lvl_max: assert property (
    @(posedge tcb_ifu) disable iff (!arst_n)
    lvl <= trace_pkg::trace_lvl_t'(DEPTH)
  );

  // the reader only takes a head record that is present
  a_lvl_min: assert property (
    @(posedge tcb_ifu) disable iff (!arst_n)
    pop.rdy |-> pop.vld
  );

endmodule

//--- trace_capture/trace_capture.sv
////////////////////
// builds one trace record per fetched instruction
// watches fetch, load/store and write-back, never stalls the core
////////////////////

`include "trace_settings.svh"

module trace_capture (
  input  logic                    tcb_ifu,
  input  logic                    arst_n,
  // instruction fetch bus
  input  logic                    ifu_vld,
  input  logic                    ifu_rdy,
  input  tcb_pkg::tcb_req_t       ifu_req,
  input  logic [`TRACE_XLEN-1:0]  ifu_rdt,
  // load/store bus
  input  logic                    lsu_vld,
  input  logic                    lsu_rdy,
  input  tcb_pkg::tcb_req_t       lsu_req,
  input  logic [`TRACE_XLEN-1:0]  lsu_rdt,
  // register write-back
  input  logic                    gpr_wen,
  input  logic [`TRACE_GLOG-1:0]  gpr_wid,
  input  logic [`TRACE_XLEN-1:0]  gpr_wdt,
  // record push towards the buffer
  output logic                    push_vld,
  input  logic                    push_rdy,
  output trace_pkg::trace_rec_t   push_rec,
  // lost record counter
  input  logic                    drop_clr,
  output logic [`TRACE_DROP_W-1:0] drop_cnt
);

  logic ifu_trn;
  logic lsu_trn;
  logic lsu_ld;
  // fetch response due this cycle
  logic ifu_dly;
  // load response due for the open or the closing record
  logic ld_acc;
  logic ld_cls;
  // a window has been opened since reset
  logic acc_vld;
  logic cls_vld;
  // open window, its next value, a fresh window
  trace_pkg::trace_rec_t acc, acc_nxt, acc_opn;
  // closed record waiting for load data
  trace_pkg::trace_rec_t cls, cls_fin;
  logic [`TRACE_XLEN-1:0] insn;

  assign ifu_trn = ifu_vld & ifu_rdy;
  assign lsu_trn = lsu_vld & lsu_rdy;
  assign lsu_ld  = lsu_trn & ~lsu_req.wen;

  // compressed instructions keep only the low half
  assign insn = (ifu_rdt[1:0] == 2'b11) ? ifu_rdt : {16'h0000, ifu_rdt[15:0]};

  ////////////////////
  // window accumulation
  ////////////////////

  always_comb begin
    acc_nxt = acc;
    if (ifu_dly) acc_nxt.insn = insn;
    // writes to x0 are not recorded
    if (gpr_wen && (gpr_wid != '0)) begin
      acc_nxt.gpr_vld = 1'b1;
      acc_nxt.gpr_wid = gpr_wid;
      acc_nxt.gpr_wdt = gpr_wdt;
    end
    // late load data first, a newer transfer overrides it
    if (ld_acc) acc_nxt.lsu_dat = lsu_rdt;
    if (lsu_trn) begin
      acc_nxt.lsu_vld = 1'b1;
      acc_nxt.lsu_wen = lsu_req.wen;
      acc_nxt.lsu_adr = lsu_req.adr;
      acc_nxt.lsu_dat = lsu_req.wen ? lsu_req.wdt : '0;
    end
  end

  // new window starts with only the fetch address
  always_comb begin
    acc_opn    = '0;
    acc_opn.pc = ifu_req.adr;
  end

  // load transferred in the closing cycle lands here
  always_comb begin
    cls_fin = cls;
    if (ld_cls) cls_fin.lsu_dat = lsu_rdt;
  end

  ////////////////////
  // pipeline control
  ////////////////////

  always_ff @(posedge tcb_ifu or negedge arst_n) begin
    if (!arst_n) begin
      ifu_dly  <= 1'b0;
      ld_acc   <= 1'b0;
      ld_cls   <= 1'b0;
      acc_vld  <= 1'b0;
      cls_vld  <= 1'b0;
      push_vld <= 1'b0;
    end else begin
      ifu_dly  <= ifu_trn;
      ld_acc   <= lsu_ld & ~ifu_trn;
      ld_cls   <= lsu_ld & ifu_trn;
      if (ifu_trn) acc_vld <= 1'b1;
      // first fetch after reset only opens a window
      cls_vld  <= ifu_trn & acc_vld;
      push_vld <= cls_vld;
    end
  end

  always_ff @(posedge tcb_ifu) begin
    acc <= ifu_trn ? acc_opn : acc_nxt;
    if (ifu_trn) cls <= acc_nxt;
    if (cls_vld) push_rec <= cls_fin;
  end

  // saturating count of records lost to a full buffer
  always_ff @(posedge tcb_ifu or negedge arst_n) begin
    if (!arst_n) begin
      drop_cnt <= '0;
    end else if (drop_clr) begin
      drop_cnt <= {{(`TRACE_DROP_W-1){1'b0}}, push_vld & ~push_rdy};
    end else if (push_vld && !push_rdy && (drop_cnt != '1)) begin
      drop_cnt <= drop_cnt + 1'b1;
    end
  end

  // pc of every record comes from a defined address
  a_ifu_adr_known: assert property (
    @(posedge tcb_ifu) disable iff (!arst_n)
    ifu_trn |-> !$isunknown(ifu_req.adr)
  );

endmodule

//--- common/trace_stream_if.sv
////////////////////
// head-of-buffer link between record buffer and APB reader
// src side presents records, snk side accepts them with rdy
////////////////////

interface trace_stream_if;

  // head record present
  logic                   vld;
  // consumer takes the head record
  logic                   rdy;
  // head record and current fill level
  trace_pkg::trace_rec_t  rec;
  trace_pkg::trace_lvl_t  lvl;

  // buffer side
  modport src (output vld, output rec, output lvl, input rdy);

  // reader side
  modport snk (input vld, input rec, input lvl, output rdy);

endinterface

//--- common/trace_pkg.sv
////////////////////
// trace record layout and APB register map
// the record is built by capture, stored by the buffer, read over APB
////////////////////

`include "trace_settings.svh"

package trace_pkg;

  // buffer fill level, wide enough to hold the full depth
  typedef logic [$clog2(`TRACE_FIFO_DEPTH+1)-1:0] trace_lvl_t;

  // one committed instruction
  typedef struct packed {
    // fetch address and instruction
    logic [`TRACE_XLEN-1:0] pc;
    logic [`TRACE_XLEN-1:0] insn;
    // last nonzero register write in the window
    logic                   gpr_vld;
    logic [`TRACE_GLOG-1:0] gpr_wid;
    logic [`TRACE_XLEN-1:0] gpr_wdt;
    // last load or store in the window
    logic                   lsu_vld;
    logic                   lsu_wen;
    logic [`TRACE_XLEN-1:0] lsu_adr;
    // store data or load response
    logic [`TRACE_XLEN-1:0] lsu_dat;
  } trace_rec_t;

  // APB word addresses, byte address is index*4
  typedef enum logic [2:0] {
    REG_STATUS  = 3'd0,
    REG_PC      = 3'd1,
    REG_INSN    = 3'd2,
    REG_GPR_CTL = 3'd3,
    REG_GPR_DAT = 3'd4,
    REG_LSU_CTL = 3'd5,
    REG_LSU_ADR = 3'd6,
    // reading this one pops the head record
    REG_LSU_DAT = 3'd7
  } trace_reg_e;

endpackage

//--- common/tcb_pkg.sv
////////////////////
// types for the tightly coupled buses (TCB) of the core
// shared by the capture block and the top level
////////////////////

`include "trace_settings.svh"

package tcb_pkg;

  // one bus word, used for address and data alike
  typedef logic [`TRACE_XLEN-1:0] tcb_word_t;

  // request side of a fetch or load/store transfer
  // a transfer happens when vld and rdy are both high,
  // read data follows one cycle later
  typedef struct packed {
    // byte address
    tcb_word_t adr;
    // write enable, always low on the fetch bus
    logic      wen;
    // write data, only meaningful for stores
    tcb_word_t wdt;
  } tcb_req_t;

endpackage

//--- common/trace_settings.svh
////////////////////
// sizing macros for the commit trace unit
// included by packages and RTL that size ports or storage
////////////////////

`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// data and address width of the watched buses
`define TRACE_XLEN 32

// register index width, 32 GPRs
`define TRACE_GLOG 5

// record buffer depth and drop counter width
`define TRACE_FIFO_DEPTH 8
`define TRACE_DROP_W 16

`endif
